// ==== sources.f ====
design/cache_pkg.sv
design/l1_cache.sv
design/line_arbiter.sv
design/cache_hierarchy.sv
dv/mem_model.sv
dv/cache_hierarchy_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module cache_hierarchy_tb -o sim

output="$(./obj_dir/sim)"
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// ==== dv/cache_hierarchy_tb.sv ====
module cache_hierarchy_tb;

    // one table row, port 0 is the instruction side and 1 the data side
    typedef struct packed {
        logic                         port;
        logic                         with_next;
        cache_pkg::cpu_op_e           op;
        logic [cache_pkg::addr_w-1:0] address;
        logic [3:0]                   byte_enable;
        logic [cache_pkg::word_w-1:0] wdata;
    } entry_t;

    logic                         clk;
    logic                         rst_n;
    cache_pkg::cpu_req_t          imem_req;
    cache_pkg::cpu_resp_t         imem_resp;
    logic                         imem_ready;
    cache_pkg::cpu_req_t          dmem_req;
    cache_pkg::cpu_resp_t         dmem_resp;
    logic                         dmem_ready;
    cache_pkg::mem_req_t          pmem_req;
    logic                         pmem_resp;
    logic [cache_pkg::line_w-1:0] pmem_rdata;

    entry_t      entries[$];
    string       names[$];
    logic [31:0] ref_mem [logic [31:0]];
    logic [31:0] rnd [3];
    int          seed = 49;
    int          timeout_cycles = 200;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          idx;

    cache_hierarchy cache_hierarchy_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_req   (imem_req),
        .imem_resp  (imem_resp),
        .imem_ready (imem_ready),
        .dmem_req   (dmem_req),
        .dmem_resp  (dmem_resp),
        .dmem_ready (dmem_ready),
        .pmem_req   (pmem_req),
        .pmem_resp  (pmem_resp),
        .pmem_rdata (pmem_rdata)
    );

    mem_model memory (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (pmem_req),
        .resp  (pmem_resp),
        .rdata (pmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] ref_read(input logic [31:0] address);
        logic [31:0] word_addr;
        word_addr = {address[31:2], 2'b00};
        if (ref_mem.exists(word_addr)) begin
            return ref_mem[word_addr];
        end
        return word_addr ^ 32'hA5A5_0000;
    endfunction

    task automatic ref_write(input logic [31:0] address, input logic [3:0] be,
                             input logic [31:0] data);
        logic [31:0] word;
        word = ref_read(address);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        ref_mem[{address[31:2], 2'b00}] = word;
    endtask

    task automatic add_entry(input string name, input logic port, input cache_pkg::cpu_op_e op,
                             input logic [31:0] address, input logic [3:0] be,
                             input logic [31:0] wdata, input logic with_next);
        entry_t e;
        e.port        = port;
        e.with_next   = with_next;
        e.op          = op;
        e.address     = address;
        e.byte_enable = be;
        e.wdata       = wdata;
        entries.push_back(e);
        names.push_back(name);
    endtask

    task automatic report_test(input string name, input bit ok);
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("%-18s %s", name, ok ? "pass" : "fail");
    endtask

    task automatic build_table();
        for (int i = 0; i < 3; i++) begin
            rnd[i] = $random(seed);
        end
        add_entry("ifetch_miss", 1'b0, cache_pkg::op_read, 32'h0000_0100, 4'h0, 32'h0, 1'b0);
        add_entry("ifetch_line_hit", 1'b0, cache_pkg::op_read, 32'h0000_0114, 4'h0, 32'h0, 1'b0);
        add_entry("store_low_half", 1'b1, cache_pkg::op_write, 32'h0000_0240, 4'b0011, rnd[0], 1'b0);
        add_entry("store_high_half", 1'b1, cache_pkg::op_write, 32'h0000_0240, 4'b1100, rnd[1], 1'b0);
        add_entry("load_merged", 1'b1, cache_pkg::op_read, 32'h0000_0240, 4'h0, 32'h0, 1'b0);
        // same set 3 with tags 3 and 4 forces a dirty eviction
        add_entry("store_victim", 1'b1, cache_pkg::op_write, 32'h0000_0364, 4'hf, rnd[2], 1'b0);
        add_entry("load_conflict", 1'b1, cache_pkg::op_read, 32'h0000_0464, 4'h0, 32'h0, 1'b0);
        add_entry("load_after_evict", 1'b1, cache_pkg::op_read, 32'h0000_0364, 4'h0, 32'h0, 1'b0);
        add_entry("ifetch_evicted", 1'b0, cache_pkg::op_read, 32'h0000_0364, 4'h0, 32'h0, 1'b0);
        // pairs issued in the same cycle on both ports
        add_entry("dual_ifetch", 1'b0, cache_pkg::op_read, 32'h0000_0584, 4'h0, 32'h0, 1'b1);
        add_entry("dual_load", 1'b1, cache_pkg::op_read, 32'h0000_06a8, 4'h0, 32'h0, 1'b0);
        add_entry("dual_ifetch_2", 1'b0, cache_pkg::op_read, 32'h0000_07c0, 4'h0, 32'h0, 1'b1);
        add_entry("dual_store", 1'b1, cache_pkg::op_write, 32'h0000_08e4, 4'hf, ~rnd[0], 1'b0);
        add_entry("load_dual_store", 1'b1, cache_pkg::op_read, 32'h0000_08e4, 4'h0, 32'h0, 1'b0);
    endtask

    task automatic check_reset_state();
        bit ok;
        ok = 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            assert (imem_ready && dmem_ready) else begin
                $display("reset_state: a ready output is low after reset");
                ok = 1'b0;
            end
            assert (!imem_resp.resp && !dmem_resp.resp) else begin
                $display("reset_state: a resp pulsed with no request");
                ok = 1'b0;
            end
            assert (pmem_req.op == cache_pkg::mem_idle) else begin
                $display("reset_state: the memory port left idle with no request");
                ok = 1'b0;
            end
        end
        report_test("reset_state", ok);
    endtask

    // issue one entry, or two on different ports in the same cycle
    task automatic run_group(input int first, input int count);
        cache_pkg::cpu_req_t req;
        int                  slot [2] = '{-1, -1};
        logic [31:0]         expected [2];
        logic [31:0]         got [2];
        bit                  seen [2] = '{1'b0, 1'b0};
        bit                  all_ready;
        bit                  all_seen;
        bit                  ok;
        int                  waited;
        int                  e;
        req = '0;
        for (int k = 0; k < count; k++) begin
            slot[entries[first+k].port] = first + k;
        end

        all_ready = 1'b0;
        waited = 0;
        while (!all_ready && waited < timeout_cycles) begin
            @(negedge clk);
            all_ready = (slot[0] < 0 || imem_ready) && (slot[1] < 0 || dmem_ready);
            waited++;
        end
        assert (all_ready) else begin
            $display("%s: the cache port never became ready", names[first]);
        end
        if (!all_ready) begin
            for (int k = 0; k < count; k++) begin
                report_test(names[first+k], 1'b0);
            end
            return;
        end

        @(posedge clk);
        for (int p = 0; p < 2; p++) begin
            if (slot[p] >= 0) begin
                e = slot[p];
                req.valid       = 1'b1;
                req.op          = entries[e].op;
                req.address     = entries[e].address;
                req.byte_enable = entries[e].byte_enable;
                req.wdata       = entries[e].wdata;
                if (entries[e].op == cache_pkg::op_write) begin
                    ref_write(entries[e].address, entries[e].byte_enable, entries[e].wdata);
                end else begin
                    expected[p] = ref_read(entries[e].address);
                end
                if (p == 0) begin
                    imem_req <= req;
                end else begin
                    dmem_req <= req;
                end
            end
        end
        @(posedge clk);
        imem_req.valid <= 1'b0;
        dmem_req.valid <= 1'b0;

        all_seen = 1'b0;
        waited = 0;
        while (!all_seen && waited < timeout_cycles) begin
            @(negedge clk);
            if (slot[0] >= 0 && imem_resp.resp) begin
                seen[0] = 1'b1;
                got[0]  = imem_resp.rdata;
            end
            if (slot[1] >= 0 && dmem_resp.resp) begin
                seen[1] = 1'b1;
                got[1]  = dmem_resp.rdata;
            end
            all_seen = (slot[0] < 0 || seen[0]) && (slot[1] < 0 || seen[1]);
            waited++;
        end

        for (int p = 0; p < 2; p++) begin
            if (slot[p] >= 0) begin
                e = slot[p];
                ok = 1'b1;
                assert (seen[p]) else begin
                    $display("%s: the cache never answered the request", names[e]);
                    ok = 1'b0;
                end
                if (seen[p] && entries[e].op == cache_pkg::op_read) begin
                    assert (got[p] == expected[p]) else begin
                        $display("Mismatch %s expected %h actual %h", names[e], expected[p], got[p]);
                        ok = 1'b0;
                    end
                end
                report_test(names[e], ok);
            end
        end
    endtask

    initial begin
        imem_req <= '0;
        dmem_req <= '0;
        rst_n    <= 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        idx = 0;
        while (idx < entries.size()) begin
            if (entries[idx].with_next) begin
                run_group(idx, 2);
                idx += 2;
            end else begin
                run_group(idx, 1);
                idx += 1;
            end
        end
        $display("%0d tests run, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/mem_model.sv ====
module mem_model (
    input  logic                            clk,
    input  logic                            rst_n,
    input  cache_pkg::mem_req_t             req,
    output logic                            resp,
    output logic [cache_pkg::line_w-1:0]    rdata
);

    // lines written back so far by line address
    logic [cache_pkg::line_w-1:0] written [logic [cache_pkg::addr_w-1:0]];
    logic [1:0]                   wait_count;
    logic [cache_pkg::addr_w-1:0] base;

    assign base = {req.address[cache_pkg::addr_w-1:cache_pkg::offset_w],
                   {cache_pkg::offset_w{1'b0}}};

    // untouched words read back as their own address xor a fixed pattern
    function automatic logic [cache_pkg::line_w-1:0] read_line(
        input logic [cache_pkg::addr_w-1:0] line_addr
    );
        logic [cache_pkg::line_w-1:0] line;
        if (written.exists(line_addr)) begin
            return written[line_addr];
        end
        for (int w = 0; w < cache_pkg::line_w / cache_pkg::word_w; w++) begin
            line[w*cache_pkg::word_w +: cache_pkg::word_w] =
                (line_addr + 32'(w * 4)) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            resp       <= 1'b0;
            rdata      <= '0;
            wait_count <= '0;
        end else begin
            resp <= 1'b0;
            if (req.op == cache_pkg::mem_idle || resp) begin
                wait_count <= '0;
            end else if (wait_count == 2'd2) begin
                // resp lands 3 cycles after the request appeared
                resp       <= 1'b1;
                wait_count <= '0;
                if (req.op == cache_pkg::mem_read) begin
                    rdata <= read_line(base);
                end else begin
                    written[base] = req.wdata;
                end
            end else begin
                wait_count <= wait_count + 2'd1;
            end
        end
    end

endmodule

// ==== design/cache_hierarchy.sv ====
module cache_hierarchy (
    input  logic                            clk,
    input  logic                            rst_n,

    input  cache_pkg::cpu_req_t             imem_req,
    output cache_pkg::cpu_resp_t            imem_resp,
    output logic                            imem_ready,

    input  cache_pkg::cpu_req_t             dmem_req,
    output cache_pkg::cpu_resp_t            dmem_resp,
    output logic                            dmem_ready,

    output cache_pkg::mem_req_t             pmem_req,
    input  logic                            pmem_resp,
    input  logic [cache_pkg::line_w-1:0]    pmem_rdata
);

    cache_pkg::mem_req_t            icache_mem_req;
    cache_pkg::mem_req_t            dcache_mem_req;
    logic                           icache_mem_resp;
    logic                           dcache_mem_resp;
    logic [cache_pkg::line_w-1:0]   line_rdata;

    // instruction side
    l1_cache icache (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (imem_req),
        .cpu_resp  (imem_resp),
        .ready     (imem_ready),
        .mem_req   (icache_mem_req),
        .mem_resp  (icache_mem_resp),
        .mem_rdata (line_rdata)
    );

    // data side
    l1_cache dcache (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (dmem_req),
        .cpu_resp  (dmem_resp),
        .ready     (dmem_ready),
        .mem_req   (dcache_mem_req),
        .mem_resp  (dcache_mem_resp),
        .mem_rdata (line_rdata)
    );

    line_arbiter arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .icache_req  (icache_mem_req),
        .dcache_req  (dcache_mem_req),
        .icache_resp (icache_mem_resp),
        .dcache_resp (dcache_mem_resp),
        .line_rdata  (line_rdata),
        .pmem_req    (pmem_req),
        .pmem_resp   (pmem_resp),
        .pmem_rdata  (pmem_rdata)
    );

endmodule

// ==== design/line_arbiter.sv ====
module line_arbiter (
    input  logic                            clk,
    input  logic                            rst_n,
    input  cache_pkg::mem_req_t             icache_req,
    input  cache_pkg::mem_req_t             dcache_req,
    output logic                            icache_resp,
    output logic                            dcache_resp,
    output logic [cache_pkg::line_w-1:0]    line_rdata,
    output cache_pkg::mem_req_t             pmem_req,
    input  logic                            pmem_resp,
    input  logic [cache_pkg::line_w-1:0]    pmem_rdata
);

    cache_pkg::arb_state_e owner;

    logic icache_pending;
    logic dcache_pending;

    assign icache_pending = (icache_req.op != cache_pkg::mem_idle);
    assign dcache_pending = (dcache_req.op != cache_pkg::mem_idle);

    // grant held for a whole transaction, one idle cycle between grants
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= cache_pkg::arb_idle;
        end else begin
            case (owner)
                cache_pkg::arb_idle: begin
                    // data side first
                    if (dcache_pending) begin
                        owner <= cache_pkg::arb_dcache;
                    end else if (icache_pending) begin
                        owner <= cache_pkg::arb_icache;
                    end
                end
                cache_pkg::arb_icache,
                cache_pkg::arb_dcache: begin
                    if (pmem_resp) begin
                        owner <= cache_pkg::arb_idle;
                    end
                end
                default: begin
                    owner <= cache_pkg::arb_idle;
                end
            endcase
        end
    end

    // request path is a plain mux on the owner
    always_comb begin
        pmem_req    = dcache_req;
        pmem_req.op = cache_pkg::mem_idle;
        case (owner)
            cache_pkg::arb_icache: begin
                pmem_req = icache_req;
            end
            cache_pkg::arb_dcache: begin
                pmem_req = dcache_req;
            end
            default: begin
                pmem_req.op = cache_pkg::mem_idle;
            end
        endcase
    end

    assign icache_resp = pmem_resp && (owner == cache_pkg::arb_icache);
    assign dcache_resp = pmem_resp && (owner == cache_pkg::arb_dcache);

    // only the owner samples it
    assign line_rdata = pmem_rdata;

endmodule

// ==== design/l1_cache.sv ====
module l1_cache (
    input  logic                            clk,
    input  logic                            rst_n,
    input  cache_pkg::cpu_req_t             cpu_req,
    output cache_pkg::cpu_resp_t            cpu_resp,
    output logic                            ready,
    output cache_pkg::mem_req_t             mem_req,
    input  logic                            mem_resp,
    input  logic [cache_pkg::line_w-1:0]    mem_rdata
);

    cache_pkg::cache_state_e state;
    cache_pkg::cache_state_e state_next;

    // per-set bookkeeping
    logic [cache_pkg::num_sets-1:0] valid_q;
    logic [cache_pkg::num_sets-1:0] dirty_q;
    logic [cache_pkg::tag_w-1:0]    tags [cache_pkg::num_sets];
    logic [cache_pkg::line_w-1:0]   lines [cache_pkg::num_sets];

    // request held for the whole transaction
    cache_pkg::cpu_req_t req_q;

    logic [cache_pkg::index_w-1:0]  in_idx;
    logic [cache_pkg::tag_w-1:0]    in_tag;
    logic                           in_hit;
    logic                           in_dirty_victim;

    logic [cache_pkg::index_w-1:0]  req_idx;
    logic [cache_pkg::tag_w-1:0]    req_tag;
    logic [cache_pkg::offset_w-3:0] word_sel;
    logic [cache_pkg::line_w-1:0]   merged_line;
    logic                           store_done;
    logic                           fill_done;

    // incoming address fields, used for the tag compare at accept time
    assign in_idx = cpu_req.address[cache_pkg::offset_w +: cache_pkg::index_w];
    assign in_tag = cpu_req.address[cache_pkg::addr_w-1 -: cache_pkg::tag_w];

    assign in_hit          = valid_q[in_idx] && (tags[in_idx] == in_tag);
    assign in_dirty_victim = valid_q[in_idx] && dirty_q[in_idx] && (tags[in_idx] != in_tag);

    // latched address fields
    assign req_idx  = req_q.address[cache_pkg::offset_w +: cache_pkg::index_w];
    assign req_tag  = req_q.address[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
    assign word_sel = req_q.address[cache_pkg::offset_w-1:2];

    assign store_done = (state == cache_pkg::st_respond) && (req_q.op == cache_pkg::op_write);
    assign fill_done  = (state == cache_pkg::st_allocate) && mem_resp;

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::st_idle: begin
                if (cpu_req.valid) begin
                    if (in_hit) begin
                        state_next = cache_pkg::st_respond;
                    end else if (in_dirty_victim) begin
                        state_next = cache_pkg::st_writeback;
                    end else begin
                        state_next = cache_pkg::st_allocate;
                    end
                end
            end
            cache_pkg::st_writeback: begin
                if (mem_resp) begin
                    state_next = cache_pkg::st_allocate;
                end
            end
            cache_pkg::st_allocate: begin
                if (mem_resp) begin
                    state_next = cache_pkg::st_respond;
                end
            end
            cache_pkg::st_respond: begin
                state_next = cache_pkg::st_idle;
            end
            default: begin
                state_next = cache_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= cache_pkg::st_idle;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            state <= state_next;
            if (fill_done) begin
                valid_q[req_idx] <= 1'b1;
                dirty_q[req_idx] <= 1'b0;
            end
            if (store_done) begin
                dirty_q[req_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_pkg::st_idle && cpu_req.valid) begin
            req_q <= cpu_req;
        end
    end

    // line and tag storage, refill first then store merge on the respond cycle
    always_ff @(posedge clk) begin
        if (fill_done) begin
            lines[req_idx] <= mem_rdata;
            tags[req_idx]  <= req_tag;
        end else if (store_done) begin
            lines[req_idx] <= merged_line;
        end
    end

    // byte merge of the store word into the resident line
    always_comb begin
        merged_line = lines[req_idx];
        for (int b = 0; b < cache_pkg::word_w / 8; b++) begin
            if (req_q.byte_enable[b]) begin
                merged_line[word_sel*cache_pkg::word_w + b*8 +: 8] = req_q.wdata[b*8 +: 8];
            end
        end
    end

    // writeback uses the victim tag, allocate uses the requested one
    always_comb begin
        mem_req.op      = cache_pkg::mem_idle;
        mem_req.address = {req_tag, req_idx, {cache_pkg::offset_w{1'b0}}};
        mem_req.wdata   = lines[req_idx];
        case (state)
            cache_pkg::st_writeback: begin
                mem_req.op      = cache_pkg::mem_write;
                mem_req.address = {tags[req_idx], req_idx, {cache_pkg::offset_w{1'b0}}};
            end
            cache_pkg::st_allocate: begin
                mem_req.op = cache_pkg::mem_read;
            end
            default: begin
                mem_req.op = cache_pkg::mem_idle;
            end
        endcase
    end

    assign ready          = (state == cache_pkg::st_idle);
    assign cpu_resp.resp  = (state == cache_pkg::st_respond);
    assign cpu_resp.rdata = lines[req_idx][word_sel*cache_pkg::word_w +: cache_pkg::word_w];

endmodule

// ==== design/cache_pkg.sv ====
package cache_pkg;

    // line geometry shared by both caches and the memory port
    localparam int addr_w   = 32;
    localparam int word_w   = 32;
    localparam int offset_w = 5;
    localparam int index_w  = 3;
    localparam int tag_w    = addr_w - index_w - offset_w;
    localparam int line_w   = 8 * (2 ** offset_w);
    localparam int num_sets = 2 ** index_w;

    typedef enum logic {
        op_read,
        op_write
    } cpu_op_e;

    typedef enum logic [1:0] {
        mem_idle,
        mem_read,
        mem_write
    } mem_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_allocate,
        st_respond
    } cache_state_e;

    typedef enum logic [1:0] {
        arb_idle,
        arb_icache,
        arb_dcache
    } arb_state_e;

    // valid is a single-cycle strobe, only legal while ready is high
    typedef struct packed {
        logic                    valid;
        cpu_op_e                 op;
        logic [addr_w-1:0]       address;
        logic [word_w/8-1:0]     byte_enable;
        logic [word_w-1:0]       wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                    resp;
        logic [word_w-1:0]       rdata;
    } cpu_resp_t;

    // held steady until pmem_resp
    typedef struct packed {
        mem_op_e                 op;
        logic [addr_w-1:0]       address;
        logic [line_w-1:0]       wdata;
    } mem_req_t;

endpackage
